/* fetch_pkg.sv */
// Fetch predictor sizes and reset address
// Branch type encoding and BTB entry layout
`default_nettype none

package fetch_pkg;

    localparam int pc_width        = 30;
    localparam int btb_entries     = 128;
    localparam int btb_ways        = 2;
    localparam int btb_sets        = btb_entries / btb_ways;
    localparam int btb_index_width = 6;
    localparam int btb_tag_width   = 12;
    localparam int ras_entries     = 32;
    localparam int ras_ptr_width   = 5;

    // Reset fetch address, in words
    localparam logic [pc_width-1:0] start_word_addr = 30'h0000_0200;

    // Conditional branches follow the counter, the rest always redirect
    typedef enum logic [1:0] {
        br_cond = 2'b00,
        br_jump = 2'b01,
        br_call = 2'b10,
        br_ret  = 2'b11
    } branch_type_e;

    typedef struct packed {
        logic [pc_width-1:0] target;
        branch_type_e        btype;
        logic [1:0]          counter;
    } btb_entry_t;

endpackage

`default_nettype wire

/* btb_way_if.sv */
// Per-way BTB bus between access logic, way storage and hit resolver
`timescale 1ns/1ps
`default_nettype none

interface btb_way_if;
    import fetch_pkg::*;

    logic [btb_index_width-1:0] lookup_index;
    logic [btb_tag_width-1:0]   lookup_tag;
    logic                       wr_en;
    logic                       wr_alloc;
    logic                       inval_en;
    btb_entry_t                 wr_entry;
    logic                       valid;
    logic                       hit;
    btb_entry_t                 rd_entry;

    // Lookup and write control, way state read back for allocation
    modport feed (
        output lookup_index, lookup_tag, wr_en, wr_alloc, inval_en, wr_entry,
        input  valid, hit
    );

    modport way (
        input  lookup_index, lookup_tag, wr_en, wr_alloc, inval_en, wr_entry,
        output valid, hit, rd_entry
    );

    modport drain (
        input hit, rd_entry
    );

endinterface

`default_nettype wire

/* pc_gen.sv */
// Word program counter, next fetch address choice
// Registered fetch pair and prediction for the translation stage
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  wire logic                                   core_clock_i,
    input  wire logic                                   core_reset_i,
    input  wire logic                                   flush_i,
    input  wire logic [fetch_pkg::pc_width-1:0]         flush_pc_i,
    input  wire logic                                   busy_i,
    input  wire logic                                   predict_en_i,
    input  wire logic                                   redirect_i,
    input  wire logic [fetch_pkg::pc_width-1:0]         target_i,
    input  wire logic                                   hit_i,
    input  wire logic [$clog2(fetch_pkg::btb_ways)-1:0] way_i,
    input  wire fetch_pkg::btb_entry_t                  entry_i,
    output logic [fetch_pkg::pc_width-1:0]              pc_o,
    output logic                                        stage_valid_o,
    output logic [fetch_pkg::pc_width-1:0]              stage_pc_o,
    output logic [1:0]                                  stage_btype_o,
    output logic [1:0]                                  stage_cntr_o,
    output logic [fetch_pkg::pc_width-1:0]              stage_target_o,
    output logic                                        stage_hit_o,
    output logic [$clog2(fetch_pkg::btb_ways)-1:0]      stage_way_o
);
    import fetch_pkg::*;

    logic [pc_width-1:0] pc_q;
    logic [pc_width-1:0] next_pc;
    logic                take;

    assign take = redirect_i & predict_en_i;

    // An odd address fetches only the upper half of its pair
    assign next_pc = take ? target_i :
                     pc_q[0] ? pc_q + pc_width'(1) : pc_q + pc_width'(2);

    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            pc_q          <= start_word_addr;
            stage_valid_o <= 1'b0;
        end else if (flush_i) begin
            pc_q          <= flush_pc_i;
            stage_valid_o <= 1'b0;
        end else if (!busy_i) begin
            pc_q          <= next_pc;
            stage_valid_o <= 1'b1;
        end
    end

    // Stage payload, only meaningful while stage_valid_o is set
    always_ff @(posedge core_clock_i) begin
        if (!busy_i && !flush_i) begin
            stage_pc_o     <= pc_q;
            stage_btype_o  <= entry_i.btype;
            stage_cntr_o   <= entry_i.counter;
            stage_target_o <= target_i;
            stage_hit_o    <= hit_i & predict_en_i;
            stage_way_o    <= way_i;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

/* btb_access.sv */
// BTB lookup address select, index and tag hash, counter step
// Per-set replacement bits and per-way write, allocate and invalidate control
`timescale 1ns/1ps
`default_nettype none

module btb_access (
    input  wire logic                           core_clock_i,
    input  wire logic                           core_reset_i,
    input  wire logic [fetch_pkg::pc_width-1:0] pc_i,
    input  wire logic                           update_i,
    input  wire logic [fetch_pkg::pc_width-1:0] update_pc_i,
    input  wire logic [fetch_pkg::pc_width-1:0] update_target_i,
    input  wire logic [1:0]                     update_type_i,
    input  wire logic [1:0]                     update_cntr_i,
    input  wire logic                           update_taken_i,
    input  wire logic                           correct_i,
    input  wire logic [fetch_pkg::pc_width-1:0] correct_pc_i,
    btb_way_if.feed                             ways [fetch_pkg::btb_ways]
);
    import fetch_pkg::*;

    logic [pc_width-1:0]         lookup_addr;
    logic [btb_index_width-1:0]  index;
    logic [btb_tag_width-1:0]    tag;
    logic [1:0]                  new_cntr;
    btb_entry_t                  new_entry;
    logic [btb_ways-1:0]         valid_vec;
    logic [btb_ways-1:0]         hit_vec;
    logic                        allocate;
    logic [$clog2(btb_ways)-1:0] alloc_way;
    logic [btb_sets-1:0]         repl_q;

    always_comb begin
        if (update_i) begin
            lookup_addr = update_pc_i;
        end else if (correct_i) begin
            lookup_addr = correct_pc_i;
        end else begin
            lookup_addr = pc_i;
        end
    end

    // Index skips the word bit so both halves of a pair share one entry
    assign index = lookup_addr[btb_index_width:1];
    assign tag   = lookup_addr[pc_width-1 -: btb_tag_width]
                 ^ lookup_addr[pc_width-btb_tag_width-1 -: btb_tag_width];

    // Saturating two-bit counter step
    always_comb begin
        new_cntr = update_cntr_i;
        if (update_taken_i && update_cntr_i != 2'b11) begin
            new_cntr = update_cntr_i + 2'd1;
        end else if (!update_taken_i && update_cntr_i != 2'b00) begin
            new_cntr = update_cntr_i - 2'd1;
        end
    end

    assign new_entry = '{target: update_target_i, btype: branch_type_e'(update_type_i),
                         counter: new_cntr};

    assign allocate = update_i & ~(|hit_vec);

    // First invalid way wins, way 0 first, otherwise the set's replacement bit
    always_comb begin
        alloc_way = repl_q[index];
        for (int i = btb_ways - 1; i >= 0; i--) begin
            if (!valid_vec[i]) begin
                alloc_way = i[$clog2(btb_ways)-1:0];
            end
        end
    end

    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            repl_q <= '0;
        end else if (allocate && &valid_vec) begin
            repl_q[index] <= ~repl_q[index];
        end
    end

    for (genvar g = 0; g < btb_ways; g++) begin : g_way
        logic alloc_here;

        assign alloc_here           = allocate && alloc_way == g;
        assign valid_vec[g]         = ways[g].valid;
        assign hit_vec[g]           = ways[g].hit;
        assign ways[g].lookup_index = index;
        assign ways[g].lookup_tag   = tag;
        assign ways[g].wr_entry     = new_entry;
        assign ways[g].wr_alloc     = alloc_here;
        assign ways[g].wr_en        = (update_i && hit_vec[g]) || alloc_here;
        // Correction only acts when no update shares the cycle
        assign ways[g].inval_en     = correct_i && !update_i && hit_vec[g];
    end

endmodule

`default_nettype wire

/* btb_way.sv */
// One BTB way: valid bits, tags and entries per set
`timescale 1ns/1ps
`default_nettype none

module btb_way (
    input  wire logic core_clock_i,
    input  wire logic core_reset_i,
    btb_way_if.way    port
);
    import fetch_pkg::*;

    logic [btb_sets-1:0]      valid_q;
    logic [btb_tag_width-1:0] tag_mem   [btb_sets];
    btb_entry_t               entry_mem [btb_sets];

    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            valid_q <= '0;
        end else if (port.wr_en) begin
            valid_q[port.lookup_index] <= 1'b1;
        end else if (port.inval_en) begin
            valid_q[port.lookup_index] <= 1'b0;
        end
    end

    // A rewrite of a hitting entry keeps its tag
    always_ff @(posedge core_clock_i) begin
        if (port.wr_en) begin
            entry_mem[port.lookup_index] <= port.wr_entry;
        end
        if (port.wr_alloc) begin
            tag_mem[port.lookup_index] <= port.lookup_tag;
        end
    end

    assign port.valid    = valid_q[port.lookup_index];
    assign port.hit      = port.valid && tag_mem[port.lookup_index] == port.lookup_tag;
    assign port.rd_entry = entry_mem[port.lookup_index];

endmodule

`default_nettype wire

/* btb_resolve.sv */
// Hit way selection, return target substitution and redirect decision
`timescale 1ns/1ps
`default_nettype none

module btb_resolve (
    input  wire logic                           flush_i,
    input  wire logic [fetch_pkg::pc_width-1:0] ras_top_i,
    btb_way_if.drain                            ways [fetch_pkg::btb_ways],
    output logic                                hit_o,
    output logic [$clog2(fetch_pkg::btb_ways)-1:0] way_o,
    output fetch_pkg::btb_entry_t               entry_o,
    output logic [fetch_pkg::pc_width-1:0]      target_o,
    output logic                                redirect_o
);
    import fetch_pkg::*;

    logic [btb_ways-1:0] hit_vec;
    btb_entry_t          entry_arr [btb_ways];

    for (genvar g = 0; g < btb_ways; g++) begin : g_way
        assign hit_vec[g]   = ways[g].hit;
        assign entry_arr[g] = ways[g].rd_entry;
    end

    // Highest hitting way wins
    always_comb begin
        way_o = '0;
        for (int i = 0; i < btb_ways; i++) begin
            if (hit_vec[i]) begin
                way_o = i[$clog2(btb_ways)-1:0];
            end
        end
    end

    assign entry_o  = entry_arr[way_o];
    assign hit_o    = (|hit_vec) & ~flush_i;
    assign target_o = (entry_o.btype == br_ret) ? ras_top_i : entry_o.target;

    // Conditional branches need the counter's taken half
    assign redirect_o = hit_o && (entry_o.btype != br_cond || entry_o.counter[1]);

endmodule

`default_nettype wire

/* return_stack.sv */
// Return address stack with speculative and committed pointers
`timescale 1ns/1ps
`default_nettype none

module return_stack (
    input  wire logic                           core_clock_i,
    input  wire logic                           core_reset_i,
    input  wire logic                           push_pred_i,
    input  wire logic                           pop_pred_i,
    input  wire logic [fetch_pkg::pc_width-1:0] push_pc_i,
    input  wire logic                           update_i,
    input  wire logic [1:0]                     update_type_i,
    input  wire logic [fetch_pkg::pc_width-1:0] update_pc_i,
    output logic [fetch_pkg::pc_width-1:0]      top_o
);
    import fetch_pkg::*;

    logic [pc_width-1:0]      stack_mem [ras_entries];
    logic [ras_ptr_width-1:0] spec_q;
    logic [ras_ptr_width-1:0] real_q;
    logic [ras_ptr_width-1:0] spec_inc;
    logic [ras_ptr_width-1:0] real_inc;
    logic [ras_ptr_width-1:0] real_dec;
    logic                     call_upd;
    logic                     ret_upd;

    assign call_upd = update_i && update_type_i == br_call;
    assign ret_upd  = update_i && update_type_i == br_ret;
    assign spec_inc = spec_q + 1'b1;
    assign real_inc = real_q + 1'b1;
    assign real_dec = real_q - 1'b1;

    // Resolved calls and returns resync the speculative pointer
    always_ff @(posedge core_clock_i) begin
        if (core_reset_i) begin
            spec_q <= '0;
            real_q <= '0;
        end else if (call_upd) begin
            real_q <= real_inc;
            spec_q <= real_inc;
        end else if (ret_upd) begin
            real_q <= real_dec;
            spec_q <= real_dec;
        end else if (push_pred_i) begin
            spec_q <= spec_inc;
        end else if (pop_pred_i) begin
            spec_q <= spec_q - 1'b1;
        end
    end

    // Return address is the pair after the call
    always_ff @(posedge core_clock_i) begin
        if (call_upd) begin
            stack_mem[real_inc] <= update_pc_i + pc_width'(2);
        end else if (push_pred_i && !ret_upd) begin
            stack_mem[spec_inc] <= push_pc_i + pc_width'(2);
        end
    end

    assign top_o = stack_mem[spec_q];

endmodule

`default_nettype wire

/* fetch_predict_top.sv */
// Fetch address generator top level with BTB and return stack
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_top (
    input  wire logic                                   core_clock_i,
    input  wire logic                                   core_reset_i,
    input  wire logic                                   flush_i,
    input  wire logic [fetch_pkg::pc_width-1:0]         flush_pc_i,
    input  wire logic                                   busy_i,
    input  wire logic                                   predict_en_i,
    input  wire logic                                   update_i,
    input  wire logic [fetch_pkg::pc_width-1:0]         update_pc_i,
    input  wire logic [fetch_pkg::pc_width-1:0]         update_target_i,
    input  wire logic [1:0]                             update_type_i,
    input  wire logic [1:0]                             update_cntr_i,
    input  wire logic                                   update_taken_i,
    input  wire logic                                   correct_i,
    input  wire logic [fetch_pkg::pc_width-1:0]         correct_pc_i,
    output logic                                        stage_valid_o,
    output logic [fetch_pkg::pc_width-1:0]              stage_pc_o,
    output logic [1:0]                                  stage_btype_o,
    output logic [1:0]                                  stage_cntr_o,
    output logic [fetch_pkg::pc_width-1:0]              stage_target_o,
    output logic                                        stage_hit_o,
    output logic [$clog2(fetch_pkg::btb_ways)-1:0]      stage_way_o
);
    import fetch_pkg::*;

    logic [pc_width-1:0]         pc;
    logic                        hit;
    logic [$clog2(btb_ways)-1:0] way;
    btb_entry_t                  entry;
    logic [pc_width-1:0]         target;
    logic [pc_width-1:0]         ras_top;
    logic                        redirect;
    logic                        push_pred;
    logic                        pop_pred;

    btb_way_if way_bus [btb_ways] ();

    // Stack moves only for predictions the fetch stage actually takes
    assign push_pred = hit && entry.btype == br_call && !busy_i && !flush_i;
    assign pop_pred  = hit && entry.btype == br_ret && !busy_i && !flush_i;

    pc_gen i_pc_gen (
        .core_clock_i, .core_reset_i, .flush_i, .flush_pc_i, .busy_i, .predict_en_i,
        .redirect_i (redirect),
        .target_i   (target),
        .hit_i      (hit),
        .way_i      (way),
        .entry_i    (entry),
        .pc_o       (pc),
        .stage_valid_o, .stage_pc_o, .stage_btype_o, .stage_cntr_o,
        .stage_target_o, .stage_hit_o, .stage_way_o
    );

    btb_access i_btb_access (
        .core_clock_i, .core_reset_i,
        .pc_i (pc),
        .update_i, .update_pc_i, .update_target_i, .update_type_i, .update_cntr_i,
        .update_taken_i, .correct_i, .correct_pc_i,
        .ways (way_bus)
    );

    for (genvar g = 0; g < btb_ways; g++) begin : g_btb_way
        btb_way i_btb_way (
            .core_clock_i, .core_reset_i,
            .port (way_bus[g])
        );
    end

    btb_resolve i_btb_resolve (
        .flush_i,
        .ras_top_i  (ras_top),
        .ways       (way_bus),
        .hit_o      (hit),
        .way_o      (way),
        .entry_o    (entry),
        .target_o   (target),
        .redirect_o (redirect)
    );

    return_stack i_return_stack (
        .core_clock_i, .core_reset_i,
        .push_pred_i (push_pred),
        .pop_pred_i  (pop_pred),
        .push_pc_i   (pc),
        .update_i, .update_type_i, .update_pc_i,
        .top_o       (ras_top)
    );

endmodule

`default_nettype wire

/* fetch_predict_checker.sv */
// Concurrent checks on the fetch stage outputs, bound to the top level
`timescale 1ns/1ps
`default_nettype none

module fetch_predict_checker (
    input wire logic                                   core_clock_i,
    input wire logic                                   core_reset_i,
    input wire logic                                   flush_i,
    input wire logic                                   busy_i,
    input wire logic                                   stage_valid_i,
    input wire logic [fetch_pkg::pc_width-1:0]         stage_pc_i,
    input wire logic                                   stage_hit_i,
    input wire logic [$clog2(fetch_pkg::btb_ways)-1:0] stage_way_i
);

    int fail_count = 0;

    // No fetch output in the cycle after reset or flush
    assert property (@(posedge core_clock_i) (core_reset_i || flush_i) |=> !stage_valid_i)
        else begin
            fail_count++;
            $error("stage output valid right after reset or flush");
        end

    // Busy freezes the stage registers
    assert property (@(posedge core_clock_i) disable iff (core_reset_i)
        (busy_i && !flush_i) |=> $stable(stage_valid_i) && $stable(stage_pc_i)
                                 && $stable(stage_hit_i) && $stable(stage_way_i))
        else begin
            fail_count++;
            $error("stage output changed during a busy cycle");
        end

    assert property (@(posedge core_clock_i) disable iff (core_reset_i)
        (!busy_i && !flush_i) |=> stage_valid_i)
        else begin
            fail_count++;
            $error("no stage output after a free cycle");
        end

endmodule

bind fetch_predict_top fetch_predict_checker i_fetch_predict_checker (
    .core_clock_i,
    .core_reset_i,
    .flush_i,
    .busy_i,
    .stage_valid_i (stage_valid_o),
    .stage_pc_i    (stage_pc_o),
    .stage_hit_i   (stage_hit_o),
    .stage_way_i   (stage_way_o)
);

`default_nettype wire

/* tb_fetch_predict.sv */
// Testbench for the fetch address generator
// Random stimulus, reference model of BTB, return stack and pc, output checks
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_predict;
    import fetch_pkg::*;

    localparam int                  run_cycles  = 6000;
    localparam int                  wait_limit  = 16;
    localparam logic [pc_width-1:0] window_base = 30'h200;
    localparam logic [pc_width-1:0] call_addr   = 30'h300;
    localparam logic [pc_width-1:0] ret_addr    = 30'h340;

    logic                core_clock_i;
    logic                core_reset_i;
    logic                flush_i;
    logic [pc_width-1:0] flush_pc_i;
    logic                busy_i;
    logic                predict_en_i;
    logic                update_i;
    logic [pc_width-1:0] update_pc_i;
    logic [pc_width-1:0] update_target_i;
    logic [1:0]          update_type_i;
    logic [1:0]          update_cntr_i;
    logic                update_taken_i;
    logic                correct_i;
    logic [pc_width-1:0] correct_pc_i;
    logic                stage_valid_o;
    logic [pc_width-1:0] stage_pc_o;
    logic [1:0]          stage_btype_o;
    logic [1:0]          stage_cntr_o;
    logic [pc_width-1:0] stage_target_o;
    logic                stage_hit_o;
    logic                stage_way_o;

    // Reference model state
    logic                     m_valid [btb_ways][btb_sets];
    logic [btb_tag_width-1:0] m_tag   [btb_ways][btb_sets];
    btb_entry_t               m_entry [btb_ways][btb_sets];
    logic                     m_repl  [btb_sets];
    logic [pc_width-1:0]      m_stack [ras_entries];
    logic [ras_ptr_width-1:0] m_spec;
    logic [ras_ptr_width-1:0] m_real;
    logic [pc_width-1:0]      m_pc;
    logic                     exp_valid;
    logic [pc_width-1:0]      exp_pc;
    logic                     exp_hit;
    logic                     exp_way;
    btb_entry_t               exp_entry;

    int seed;
    int errors;
    int checks;

    fetch_predict_top i_fetch_predict_top (.*);

    initial begin
        core_clock_i = 1'b0;
        forever #4 core_clock_i = ~core_clock_i;
    end

    function automatic logic [1:0] step_counter(input logic [1:0] cntr, input logic taken);
        if (taken) begin
            return (cntr == 2'd3) ? cntr : cntr + 2'd1;
        end else begin
            return (cntr == 2'd0) ? cntr : cntr - 2'd1;
        end
    endfunction

    // Addresses stay in a small window so installed branches get fetched
    function automatic logic [pc_width-1:0] rand_addr();
        return window_base + pc_width'($random(seed) & 511);
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        errors++;
        $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, want);
    endtask

    // Advances the model by one clock edge from the inputs applied before it
    task automatic model_edge();
        logic [pc_width-1:0]        cur;
        logic [pc_width-1:0]        laddr;
        logic [btb_index_width-1:0] idx;
        logic [btb_tag_width-1:0]   tg;
        logic [btb_ways-1:0]        raw_hit;
        logic                       hit;
        logic                       redir;
        logic [pc_width-1:0]        tgt;
        btb_entry_t                 e;
        btb_entry_t                 new_e;
        int                         w;
        int                         aw;
        if (core_reset_i) begin
            m_pc = start_word_addr;
            exp_valid = 1'b0;
            m_spec = '0;
            m_real = '0;
            for (int s = 0; s < btb_sets; s++) begin
                m_repl[s] = 1'b0;
                for (int i = 0; i < btb_ways; i++) begin
                    m_valid[i][s] = 1'b0;
                end
            end
        end else begin
            cur = m_pc;
            laddr = update_i ? update_pc_i : (correct_i ? correct_pc_i : cur);
            idx = laddr[btb_index_width:1];
            tg = laddr[29:18] ^ laddr[17:6];
            for (int i = 0; i < btb_ways; i++) begin
                raw_hit[i] = m_valid[i][idx] && m_tag[i][idx] == tg;
            end
            w = raw_hit[1] ? 1 : 0;
            e = m_entry[w][idx];
            hit = (|raw_hit) && !flush_i;
            tgt = (e.btype == br_ret) ? m_stack[m_spec] : e.target;
            redir = hit && (e.btype != br_cond || e.counter[1]);

            if (flush_i) begin
                m_pc = flush_pc_i;
                exp_valid = 1'b0;
            end else if (!busy_i) begin
                exp_valid = 1'b1;
                exp_pc = cur;
                exp_hit = hit && predict_en_i;
                exp_way = w[0];
                exp_entry = e;
                exp_entry.target = tgt;
                m_pc = (redir && predict_en_i) ? tgt : cur + (cur[0] ? 30'd1 : 30'd2);
            end

            if (update_i) begin
                new_e.target = update_target_i;
                new_e.btype = branch_type_e'(update_type_i);
                new_e.counter = step_counter(update_cntr_i, update_taken_i);
                if (|raw_hit) begin
                    aw = w;
                end else if (!m_valid[0][idx]) begin
                    aw = 0;
                end else if (!m_valid[1][idx]) begin
                    aw = 1;
                end else begin
                    aw = m_repl[idx];
                    m_repl[idx] = !m_repl[idx];
                end
                if (!(|raw_hit)) begin
                    m_tag[aw][idx] = tg;
                end
                m_valid[aw][idx] = 1'b1;
                m_entry[aw][idx] = new_e;
            end else if (correct_i) begin
                for (int i = 0; i < btb_ways; i++) begin
                    if (raw_hit[i]) begin
                        m_valid[i][idx] = 1'b0;
                    end
                end
            end

            if (update_i && update_type_i == br_call) begin
                m_real = m_real + 1'b1;
                m_spec = m_real;
                m_stack[m_real] = update_pc_i + 30'd2;
            end else if (update_i && update_type_i == br_ret) begin
                m_real = m_real - 1'b1;
                m_spec = m_real;
            end else if (hit && e.btype == br_call && !busy_i) begin
                m_spec = m_spec + 1'b1;
                m_stack[m_spec] = cur + 30'd2;
            end else if (hit && e.btype == br_ret && !busy_i) begin
                m_spec = m_spec - 1'b1;
            end
        end
    endtask

    task automatic check_outputs();
        checks++;
        assert (stage_valid_o === exp_valid)
            else report_mismatch("stage_valid_o", stage_valid_o, exp_valid);
        if (exp_valid) begin
            assert (stage_pc_o === exp_pc)
                else report_mismatch("stage_pc_o", stage_pc_o, exp_pc);
            assert (stage_hit_o === exp_hit)
                else report_mismatch("stage_hit_o", stage_hit_o, exp_hit);
            // Payload fields only carry meaning with a hit
            if (exp_hit) begin
                assert (stage_btype_o === exp_entry.btype)
                    else report_mismatch("stage_btype_o", stage_btype_o, exp_entry.btype);
                assert (stage_cntr_o === exp_entry.counter)
                    else report_mismatch("stage_cntr_o", stage_cntr_o, exp_entry.counter);
                assert (stage_target_o === exp_entry.target)
                    else report_mismatch("stage_target_o", stage_target_o, exp_entry.target);
                assert (stage_way_o === exp_way)
                    else report_mismatch("stage_way_o", stage_way_o, exp_way);
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge core_clock_i);
        model_edge();
        #1;
        check_outputs();
    endtask

    task automatic set_idle();
        flush_i = 1'b0;
        busy_i = 1'b0;
        predict_en_i = 1'b1;
        update_i = 1'b0;
        correct_i = 1'b0;
    endtask

    // Resolved branch from a later stage, always paired with a flush
    task automatic install(input logic [pc_width-1:0] at, input logic [pc_width-1:0] target,
                           input logic [1:0] btype, input logic [1:0] cntr, input logic taken);
        set_idle();
        flush_i = 1'b1;
        flush_pc_i = at;
        update_i = 1'b1;
        update_pc_i = at;
        update_target_i = target;
        update_type_i = btype;
        update_cntr_i = cntr;
        update_taken_i = taken;
        step_cycle();
        set_idle();
    endtask

    task automatic flush_to(input logic [pc_width-1:0] at);
        set_idle();
        flush_i = 1'b1;
        flush_pc_i = at;
        step_cycle();
        set_idle();
    endtask

    task automatic wait_stage_pc(input logic [pc_width-1:0] addr, output int cycles);
        logic found;
        cycles = 0;
        found = 1'b0;
        while (!found && cycles < wait_limit) begin
            step_cycle();
            cycles++;
            found = stage_valid_o === 1'b1 && stage_pc_o === addr;
        end
        if (!found) begin
            errors++;
            $display("Timeout: no fetch output at address %h within %0d cycles", addr, cycles);
        end
    endtask

    task automatic drive_random();
        flush_i = ($random(seed) & 7) == 0;
        busy_i = ($random(seed) & 7) == 0;
        predict_en_i = ($random(seed) & 15) != 0;
        update_i = flush_i && ($random(seed) & 1);
        correct_i = flush_i && !update_i && ($random(seed) & 1);
        flush_pc_i = rand_addr();
        update_pc_i = rand_addr();
        update_target_i = rand_addr();
        update_type_i = 2'($random(seed));
        update_cntr_i = 2'($random(seed));
        update_taken_i = 1'($random(seed));
        // Correcting the current pc makes a hit likely
        correct_pc_i = ($random(seed) & 1) ? m_pc : rand_addr();
    endtask

    initial begin
        int cycles;
        int bound_fails;
        seed = 32'h6290_0546;
        errors = 0;
        checks = 0;
        core_reset_i = 1'b1;
        set_idle();
        flush_pc_i = '0;
        update_pc_i = '0;
        update_target_i = '0;
        update_type_i = '0;
        update_cntr_i = '0;
        update_taken_i = 1'b0;
        correct_pc_i = '0;
        repeat (8) step_cycle();
        core_reset_i = 1'b0;
        wait_stage_pc(start_word_addr, cycles);
        assert (cycles == 1) else report_mismatch("cycles to first output", cycles, 1);

        // Resolved calls write every stack slot once
        for (int i = 0; i < ras_entries; i++) begin
            install(rand_addr(), rand_addr(), br_call, 2'd0, 1'b1);
        end

        // Predicted call then predicted return lands on the pair after the call
        install(call_addr, ret_addr, br_call, 2'd0, 1'b1);
        install(ret_addr, 30'h0, br_ret, 2'd0, 1'b1);
        flush_to(call_addr);
        wait_stage_pc(call_addr, cycles);
        assert (cycles == 1) else report_mismatch("cycles after flush", cycles, 1);
        wait_stage_pc(call_addr + 30'd2, cycles);
        assert (cycles == 2) else report_mismatch("cycles to return target", cycles, 2);

        for (int n = 0; n < run_cycles; n++) begin
            drive_random();
            step_cycle();
        end

        bound_fails = i_fetch_predict_top.i_fetch_predict_checker.fail_count;
        $display("Cycles checked: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, bound_fails);
        if (errors == 0 && bound_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
fetch_pkg.sv
btb_way_if.sv
pc_gen.sv
btb_access.sv
btb_way.sv
btb_resolve.sv
return_stack.sv
fetch_predict_top.sv
fetch_predict_checker.sv
tb_fetch_predict.sv
